//--- logic/stream_settings.svh
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// Data bits carried by every beat.
`define STREAM_DATA_WIDTH 16

// Ready buffers chained on the merged output.
// Must be at least 1.
`define STREAM_OUT_SLICES 2

`endif

//--- logic/stream_pkg.sv
`include "stream_settings.svh"

package stream_pkg;

    // ------------------------------
    // Beat layouts
    // ------------------------------

    // One input beat, data and last flag.
    typedef struct packed {
        logic [`STREAM_DATA_WIDTH-1:0] tdata;
        logic                          tlast;
    } in_beat_t;

    // One merged beat, tagged with the source number.
    typedef struct packed {
        logic                          tid;
        logic [`STREAM_DATA_WIDTH-1:0] tdata;
        logic                          tlast;
    } out_beat_t;

    // ------------------------------
    // Arbiter state
    // ------------------------------

    // Idle, or a packet open from source 0 or source 1.
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_SRC0 = 2'd1,
        ARB_SRC1 = 2'd2
    } arb_state_t;

endpackage

//--- logic/stream_ready_buffer.sv
`timescale 1ns/1ps

`include "stream_settings.svh"

// One-beat slice on a valid/ready link.
// Cuts the ready path with a register.
// Forward path stays zero latency while the slice is empty.
module stream_ready_buffer #(
    int WIDTH = `STREAM_DATA_WIDTH
) (
    input  logic             aclk,
    input  logic             areset_n,
    input  logic             rx_valid,
    input  logic [WIDTH-1:0] rx_data,
    output logic             rx_ready,
    output logic             tx_valid,
    output logic [WIDTH-1:0] tx_data,
    input  logic             tx_ready
);

    // ------------------------------
    // Declarations
    // ------------------------------

    // Pass-through or presenting the stored beat.
    typedef enum logic {
        BUF_IDLE,
        BUF_HELD
    } buf_state_t;

    buf_state_t       state;
    // Last beat seen while rx_ready was high.
    logic [WIDTH-1:0] held_data;

    // ------------------------------
    // Control
    // ------------------------------

    // Hold a beat that was taken in while the sink stalled.
    // Release it as soon as the sink is ready again.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= BUF_IDLE;
        end else begin
            unique case (state)
                BUF_IDLE: begin
                    // Accepted upstream, refused downstream.
                    if (rx_valid && rx_ready && !tx_ready) begin
                        state <= BUF_HELD;
                    end
                end
                BUF_HELD: begin
                    if (tx_ready) begin
                        state <= BUF_IDLE;
                    end
                end
                default: begin
                    state <= BUF_IDLE;
                end
            endcase
        end
    end

    // Upstream ready is downstream ready, one cycle late.
    // Low after reset, so nothing enters before the sink is seen.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rx_ready <= 1'b0;
        end else begin
            rx_ready <= tx_ready;
        end
    end

    // ------------------------------
    // Payload
    // ------------------------------

    // Capture on every open cycle.
    // rx_ready is low while held, so the stored beat is safe.
    always_ff @(posedge aclk) begin
        if (rx_ready) begin
            held_data <= rx_data;
        end
    end

    // Output select.
    always_comb begin
        unique case (state)
            BUF_HELD: begin
                tx_valid = 1'b1;
                tx_data  = held_data;
            end
            default: begin
                // Straight through, gated by our own ready.
                tx_valid = rx_valid && rx_ready;
                tx_data  = rx_data;
            end
        endcase
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // A stalled beat stays put until taken.
    assert property (@(posedge aclk) disable iff (!areset_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

    // Held state presents its beat with the input closed.
    assert property (@(posedge aclk) disable iff (!areset_n)
        state == BUF_HELD |-> tx_valid && !rx_ready);

endmodule

//--- logic/stream_packet_arbiter.sv
`timescale 1ns/1ps

`include "stream_settings.svh"

// Two-source packet arbiter.
// Grant is locked for a whole packet and alternates between packets.
// Purely combinational from inputs to outputs.
module stream_packet_arbiter (
    input  logic                  aclk,
    input  logic                  areset_n,
    input  logic                  s0_valid,
    input  stream_pkg::in_beat_t  s0_beat,
    output logic                  s0_ready,
    input  logic                  s1_valid,
    input  stream_pkg::in_beat_t  s1_beat,
    output logic                  s1_ready,
    output logic                  arb_valid,
    output stream_pkg::out_beat_t arb_beat,
    input  logic                  arb_ready
);

    // ------------------------------
    // Declarations
    // ------------------------------

    // Open packet, if any.
    stream_pkg::arb_state_t arb_state;
    // Source whose packet finished most recently.
    logic                   last_src;

    // Current grant.
    logic                   grant_en;
    logic                   grant_src;
    // Beat of the granted source.
    stream_pkg::in_beat_t   sel_beat;
    // Beat handed over this cycle.
    logic                   accept;

    // ------------------------------
    // Grant
    // ------------------------------

    always_comb begin
        grant_en  = 1'b0;
        grant_src = 1'b0;
        unique case (arb_state)
            stream_pkg::ARB_IDLE: begin
                // Both waiting, the one not served last wins.
                if (s0_valid && s1_valid) begin
                    grant_en  = 1'b1;
                    grant_src = ~last_src;
                end else if (s0_valid) begin
                    grant_en  = 1'b1;
                    grant_src = 1'b0;
                end else if (s1_valid) begin
                    grant_en  = 1'b1;
                    grant_src = 1'b1;
                end
            end
            stream_pkg::ARB_SRC0: begin
                // Locked to source 0 until its last beat.
                grant_en  = 1'b1;
                grant_src = 1'b0;
            end
            stream_pkg::ARB_SRC1: begin
                grant_en  = 1'b1;
                grant_src = 1'b1;
            end
            default: begin
                // Unused encoding, grant nothing.
                grant_en  = 1'b0;
                grant_src = 1'b0;
            end
        endcase
    end

    // ------------------------------
    // Data path and handshake
    // ------------------------------

    // Beat mux.
    assign sel_beat = grant_src ? s1_beat : s0_beat;

    // Tag with the source number.
    always_comb begin
        arb_beat.tid   = grant_src;
        arb_beat.tdata = sel_beat.tdata;
        arb_beat.tlast = sel_beat.tlast;
    end

    // Valid only from the granted source.
    assign arb_valid = grant_en && (grant_src ? s1_valid : s0_valid);

    // Ready goes to the granted source only.
    assign s0_ready = grant_en && !grant_src && arb_ready;
    assign s1_ready = grant_en && grant_src && arb_ready;

    assign accept = arb_valid && arb_ready;

    // ------------------------------
    // State
    // ------------------------------

    // Lock on a middle beat, release on the last beat.
    // last_src starts at 1 so source 0 goes first.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            arb_state <= stream_pkg::ARB_IDLE;
            last_src  <= 1'b1;
        end else if (accept) begin
            if (sel_beat.tlast) begin
                arb_state <= stream_pkg::ARB_IDLE;
                last_src  <= grant_src;
            end else if (grant_src) begin
                arb_state <= stream_pkg::ARB_SRC1;
            end else begin
                arb_state <= stream_pkg::ARB_SRC0;
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // One ready at a time.
    assert property (@(posedge aclk) disable iff (!areset_n)
        !(s0_ready && s1_ready));

    // After a middle beat, output valid follows the source of the open packet.
    assert property (@(posedge aclk) disable iff (!areset_n)
        accept && !arb_beat.tlast |=> arb_beat.tid == $past(arb_beat.tid)
            && arb_valid == ($past(arb_beat.tid) ? s1_valid : s0_valid));

    // Open packet keeps the other source out.
    assert property (@(posedge aclk) disable iff (!areset_n)
        arb_state == stream_pkg::ARB_SRC0 |-> !s1_ready);

    assert property (@(posedge aclk) disable iff (!areset_n)
        arb_state == stream_pkg::ARB_SRC1 |-> !s0_ready);

endmodule

//--- logic/stream_merge_top.sv
`timescale 1ns/1ps

`include "stream_settings.svh"

// Two-stream merge.
// Packet arbiter followed by a chain of ready buffers.
module stream_merge_top (
    input  logic                  aclk,
    input  logic                  areset_n,
    input  logic                  s0_valid,
    input  stream_pkg::in_beat_t  s0_beat,
    output logic                  s0_ready,
    input  logic                  s1_valid,
    input  stream_pkg::in_beat_t  s1_beat,
    output logic                  s1_ready,
    output logic                  m_valid,
    output stream_pkg::out_beat_t m_beat,
    input  logic                  m_ready
);

    // ------------------------------
    // Chain links
    // ------------------------------

    // Link 0 is the arbiter output.
    // Link N is the merged output.
    localparam int N = `STREAM_OUT_SLICES;

    logic                  chain_valid [0:N];
    stream_pkg::out_beat_t chain_beat  [0:N];
    logic                  chain_ready [0:N];

    // ------------------------------
    // Arbiter
    // ------------------------------

    stream_packet_arbiter u_arbiter (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .s0_valid  (s0_valid),
        .s0_beat   (s0_beat),
        .s0_ready  (s0_ready),
        .s1_valid  (s1_valid),
        .s1_beat   (s1_beat),
        .s1_ready  (s1_ready),
        .arb_valid (chain_valid[0]),
        .arb_beat  (chain_beat[0]),
        .arb_ready (chain_ready[0])
    );

    // ------------------------------
    // Ready buffers
    // ------------------------------

    // Each slice adds one cycle to the ready path only.
    genvar k;
    generate
        for (k = 0; k < N; k++) begin : g_slice
            stream_ready_buffer #(
                .WIDTH ($bits(stream_pkg::out_beat_t))
            ) u_slice (
                .aclk     (aclk),
                .areset_n (areset_n),
                .rx_valid (chain_valid[k]),
                .rx_data  (chain_beat[k]),
                .rx_ready (chain_ready[k]),
                .tx_valid (chain_valid[k+1]),
                .tx_data  (chain_beat[k+1]),
                .tx_ready (chain_ready[k+1])
            );
        end
    endgenerate

    // Chain end to the outside.
    assign m_valid      = chain_valid[N];
    assign m_beat       = chain_beat[N];
    assign chain_ready[N] = m_ready;

endmodule

//--- sim/stream_merge_tb.sv
`timescale 1ns/1ps

`include "stream_settings.svh"

module stream_merge_tb;

    // ------------------------------
    // DUT signals
    // ------------------------------

    logic                  aclk;
    logic                  areset_n;
    logic                  s0_valid;
    stream_pkg::in_beat_t  s0_beat;
    logic                  s0_ready;
    logic                  s1_valid;
    stream_pkg::in_beat_t  s1_beat;
    logic                  s1_ready;
    logic                  m_valid;
    stream_pkg::out_beat_t m_beat;
    logic                  m_ready;

    // Beats still to send, per source.
    stream_pkg::in_beat_t  send0_q[$];
    stream_pkg::in_beat_t  send1_q[$];
    // Beats still expected on the output, per source.
    stream_pkg::out_beat_t exp0_q[$];
    stream_pkg::out_beat_t exp1_q[$];
    // Output beats in arrival order.
    stream_pkg::out_beat_t obs_q[$];

    integer seed = 32'hdd4a6ff6;
    integer errors;
    integer checks;
    integer cycles;
    integer total_beats;

    stream_merge_top u_dut (
        .aclk     (aclk),
        .areset_n (areset_n),
        .s0_valid (s0_valid),
        .s0_beat  (s0_beat),
        .s0_ready (s0_ready),
        .s1_valid (s1_valid),
        .s1_beat  (s1_beat),
        .s1_ready (s1_ready),
        .m_valid  (m_valid),
        .m_beat   (m_beat),
        .m_ready  (m_ready)
    );

    // 8 ns clock.
    always #4 aclk = ~aclk;

    // Run limit grows with the traffic queued so far.
    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles > 10 * total_beats + 200) begin
            $display("Run timed out after %0d cycles with %0d errors", cycles, errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic check_beat(input stream_pkg::out_beat_t exp,
                              input stream_pkg::out_beat_t got, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            $write("ERROR %0t: %s: expected tid=%0d data=%h last=%0d",
                   $time, what, exp.tid, exp.tdata, exp.tlast);
            $display(", got tid=%0d data=%h last=%0d", got.tid, got.tdata, got.tlast);
            errors = errors + 1;
        end
    endtask

    task automatic check_level(input logic exp, input logic got, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            $display("ERROR %0t: %s: expected %b, got %b", $time, what, exp, got);
            errors = errors + 1;
        end
    endtask

    // ------------------------------
    // Drivers and sink
    // ------------------------------

    // Reset for 8 cycles with both sources offering and the sink ready.
    // Outputs quiet throughout.
    task automatic apply_reset();
        areset_n = 1'b0;
        s0_valid = 1'b1;
        s1_valid = 1'b1;
        m_ready  = 1'b1;
        repeat (8) begin
            @(posedge aclk);
            check_level(1'b0, s0_ready, "s0_ready in reset");
            check_level(1'b0, s1_ready, "s1_ready in reset");
            check_level(1'b0, m_valid, "m_valid in reset");
        end
        @(negedge aclk);
        areset_n = 1'b1;
        // First cycle out of reset, ready still on its way back.
        @(posedge aclk);
        check_level(1'b0, s0_ready, "s0_ready after reset");
        check_level(1'b0, s1_ready, "s1_ready after reset");
        check_level(1'b0, m_valid, "m_valid after reset");
        @(negedge aclk);
        s0_valid = 1'b0;
        s1_valid = 1'b0;
    endtask

    // Queue one packet of random data and its expected output.
    task automatic make_packet(input int src, input int len);
        stream_pkg::in_beat_t  beat;
        stream_pkg::out_beat_t exp;
        logic [31:0]           rnd;
        for (int i = 0; i < len; i++) begin
            rnd        = $random(seed);
            beat.tdata = rnd[`STREAM_DATA_WIDTH-1:0];
            beat.tlast = (i == len - 1);
            exp.tid    = src[0];
            exp.tdata  = beat.tdata;
            exp.tlast  = beat.tlast;
            if (src == 0) begin
                send0_q.push_back(beat);
                exp0_q.push_back(exp);
            end else begin
                send1_q.push_back(beat);
                exp1_q.push_back(exp);
            end
        end
        total_beats = total_beats + len;
    endtask

    // Present queued beats back to back, holding each until taken.
    task automatic drive_source(input int src);
        stream_pkg::in_beat_t beat;
        logic                 taken;
        while ((src == 0 && send0_q.size() > 0) || (src == 1 && send1_q.size() > 0)) begin
            @(negedge aclk);
            if (src == 0) begin
                beat     = send0_q.pop_front();
                s0_valid = 1'b1;
                s0_beat  = beat;
            end else begin
                beat     = send1_q.pop_front();
                s1_valid = 1'b1;
                s1_beat  = beat;
            end
            taken = 1'b0;
            while (!taken) begin
                @(posedge aclk);
                taken = (src == 0) ? (s0_valid && s0_ready) : (s1_valid && s1_ready);
            end
        end
        @(negedge aclk);
        if (src == 0) begin
            s0_valid = 1'b0;
        end else begin
            s1_valid = 1'b0;
        end
    endtask

    // Take every expected beat, checking each against its source queue.
    task automatic collect_output(input bit random_ready);
        stream_pkg::out_beat_t beat;
        logic [31:0]           rnd;
        int                    count;
        int                    got;
        count = exp0_q.size() + exp1_q.size();
        got   = 0;
        while (got < count) begin
            @(negedge aclk);
            rnd     = $random(seed);
            m_ready = random_ready ? rnd[0] : 1'b1;
            @(posedge aclk);
            if (m_valid && m_ready) begin
                beat = m_beat;
                obs_q.push_back(beat);
                got = got + 1;
                if (beat.tid === 1'b1 && exp1_q.size() > 0) begin
                    check_beat(exp1_q.pop_front(), beat, "source 1 beat");
                end else if (beat.tid === 1'b0 && exp0_q.size() > 0) begin
                    check_beat(exp0_q.pop_front(), beat, "source 0 beat");
                end else begin
                    $display("ERROR %0t: beat with tid %b was not expected", $time, beat.tid);
                    errors = errors + 1;
                end
            end
        end
        @(negedge aclk);
        m_ready = 1'b1;
    endtask

    // Sources, sink and leftovers for the queued traffic.
    task automatic run_traffic(input bit random_ready);
        obs_q.delete();
        fork
            drive_source(0);
            drive_source(1);
            collect_output(random_ready);
        join
        if (exp0_q.size() + exp1_q.size() != 0) begin
            $display("ERROR %0t: %0d expected beats never arrived", $time,
                     exp0_q.size() + exp1_q.size());
            errors = errors + 1;
        end
        // No extra beat may follow.
        repeat (8) begin
            @(posedge aclk);
            check_level(1'b0, m_valid, "m_valid after traffic");
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic test_pass_through();
        make_packet(0, 5);
        run_traffic(1'b0);
    endtask

    task automatic test_back_pressure();
        make_packet(0, 12);
        make_packet(1, 12);
        run_traffic(1'b1);
    endtask

    // A packet once started owns the output until its last beat.
    task automatic test_contiguity();
        logic [31:0] rnd;
        logic        open;
        logic        open_tid;
        for (int p = 0; p < 4; p++) begin
            rnd = $random(seed);
            make_packet(0, 2 + int'(rnd[2:0]));
            rnd = $random(seed);
            make_packet(1, 2 + int'(rnd[2:0]));
        end
        run_traffic(1'b1);
        open     = 1'b0;
        open_tid = 1'b0;
        foreach (obs_q[i]) begin
            if (open) begin
                check_level(open_tid, obs_q[i].tid, "tid inside an open packet");
            end
            open     = !obs_q[i].tlast;
            open_tid = obs_q[i].tid;
        end
    endtask

    // Fresh reset, so source 0 wins first.
    task automatic test_round_robin();
        @(negedge aclk);
        apply_reset();
        for (int p = 0; p < 10; p++) begin
            make_packet(0, 1);
            make_packet(1, 1);
        end
        run_traffic(1'b1);
        foreach (obs_q[i]) begin
            check_level(i[0], obs_q[i].tid, "round-robin tid");
        end
    endtask

    initial begin
        aclk        = 1'b0;
        areset_n    = 1'b0;
        s0_valid    = 1'b0;
        s0_beat     = '0;
        s1_valid    = 1'b0;
        s1_beat     = '0;
        m_ready     = 1'b0;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        total_beats = 0;

        apply_reset();
        test_pass_through();
        test_back_pressure();
        test_contiguity();
        test_round_robin();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- stream_merge_top.f
+incdir+logic
logic/stream_pkg.sv
logic/stream_ready_buffer.sv
logic/stream_packet_arbiter.sv
logic/stream_merge_top.sv
sim/stream_merge_tb.sv
